// ==== source/arb_pkg.sv ====
`default_nettype none

package arb_pkg;

   // tree shape
   localparam int NUM_REQ     = 16;
   localparam int GROUP_NUM   = 4;
   localparam int GROUP_WIDTH = NUM_REQ / GROUP_NUM;  // requesters per group

   // binary requester index
   localparam int INDEX_WIDTH = $clog2(NUM_REQ);

   // one bit per requester, requests and grants
   typedef logic [NUM_REQ-1:0] req_vec_t;

   // one bit per group
   typedef logic [GROUP_NUM-1:0] group_vec_t;

   // members of a single group
   typedef logic [GROUP_WIDTH-1:0] member_vec_t;

   // position of the granted requester
   typedef logic [INDEX_WIDTH-1:0] req_index_t;

endpackage

`default_nettype wire

// ==== source/thermo_rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

// round-robin arbiter built on thermometer codes
// the priority mask marks the positions above the last winner
module thermo_rr_arbiter #(
   parameter int WIDTH = 4
) (
   input  wire logic             clk,
   input  wire logic             reset,
   input  wire logic [WIDTH-1:0] request,
   input  wire logic             update_en,
   output logic      [WIDTH-1:0] grant,
   output logic                  any_grant
);

   logic [WIDTH-1:0] priority_mask;   // positions still ahead in the round
   logic [WIDTH-1:0] masked_request;
   logic [WIDTH-1:0] thermo_all;      // code of every request
   logic [WIDTH-1:0] thermo_masked;   // code of requests inside the mask
   logic [WIDTH-1:0] thermo_sel;
   logic [WIDTH-1:0] edge_mask;       // thermo_sel shifted up by one

   // bit i is set once any bit at or below i is set
   function automatic logic [WIDTH-1:0] thermo_code(input logic [WIDTH-1:0] vec);
      logic [WIDTH-1:0] code;
      logic             seen;
      seen = 1'b0;
      for (int i = 0; i < WIDTH; i++) begin
         seen    = seen | vec[i];
         code[i] = seen;
      end
      return code;
   endfunction

   assign masked_request = request & priority_mask;

   assign thermo_all    = thermo_code(request);
   assign thermo_masked = thermo_code(masked_request);

   // top bit of a thermometer code is the OR of its input
   assign any_grant = thermo_all[WIDTH-1];

   // fall back to the plain search once the mask holds no request
   assign thermo_sel = thermo_masked[WIDTH-1] ? thermo_masked : thermo_all;

   assign edge_mask = {thermo_sel[WIDTH-2:0], 1'b0};

   // only the lowest set bit of the code survives
   assign grant = thermo_sel ^ edge_mask;

   // next round starts just above the current winner
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         priority_mask <= '1;   // search from index 0
      end else if (update_en && any_grant) begin
         priority_mask <= edge_mask;
      end
   end

endmodule

`default_nettype wire

// ==== source/group_arbiter_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

// first level of the tree
// one member arbiter per group, each sees a slice of the request vector
module group_arbiter_bank
   import arb_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       reset,
   input  wire req_vec_t   request,
   input  wire group_vec_t group_grant,
   input  wire logic       priority_en,
   output req_vec_t        member_grant,
   output group_vec_t      group_request
);

   member_vec_t member_request [GROUP_NUM];
   member_vec_t member_win     [GROUP_NUM];
   group_vec_t  member_update;   // rotate enable per group

   for (genvar g = 0; g < GROUP_NUM; g++) begin : g_group

      // consecutive requesters form a group
      assign member_request[g] = request[g*GROUP_WIDTH +: GROUP_WIDTH];

      // a group rotates only when it wins at the top level,
      // so a losing group keeps its place among its members
      assign member_update[g] = priority_en & group_grant[g];

      thermo_rr_arbiter #(
         .WIDTH     (GROUP_WIDTH)
      ) u_member_arbiter (
         .clk       (clk),
         .reset     (reset),
         .request   (member_request[g]),
         .update_en (member_update[g]),
         .grant     (member_win[g]),
         .any_grant (group_request[g])   // OR of the group's requests
      );

      // back into the flat vector, unmasked
      assign member_grant[g*GROUP_WIDTH +: GROUP_WIDTH] = member_win[g];

   end

endmodule

`default_nettype wire

// ==== source/grant_combiner.sv ====
`timescale 1ns/1ps
`default_nettype none

// output side of the tree
// keeps the winning group's member grant and encodes it to binary
module grant_combiner
   import arb_pkg::*;
(
   input  wire req_vec_t   member_grant,
   input  wire group_vec_t group_grant,
   output req_vec_t        grant,
   output req_index_t      grant_index
);

   member_vec_t member_slice  [GROUP_NUM];
   member_vec_t member_masked [GROUP_NUM];
   req_vec_t    grant_full;

   for (genvar g = 0; g < GROUP_NUM; g++) begin : g_mask

      assign member_slice[g] = member_grant[g*GROUP_WIDTH +: GROUP_WIDTH];

      // every group has its own winner, only one may pass
      assign member_masked[g] = group_grant[g] ? member_slice[g] : '0;

      assign grant_full[g*GROUP_WIDTH +: GROUP_WIDTH] = member_masked[g];

   end

   assign grant = grant_full;

   // one-hot to binary
   // grant_full has at most one bit set, so the OR of the set positions
   // is the position itself, and zero with no grant
   always_comb begin
      grant_index = '0;
      for (int i = 0; i < NUM_REQ; i++) begin
         if (grant_full[i]) begin
            grant_index = grant_index | req_index_t'(i);
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/tree_rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

// two-level round-robin arbiter
// member arbiters per group, then one arbiter across the groups
// grant is combinational from request, priority moves on priority_en
module tree_rr_arbiter
   import arb_pkg::*;
(
   input  wire logic     clk,
   input  wire logic     reset,
   input  wire req_vec_t request,
   input  wire logic     priority_en,   // current grant consumed
   output req_vec_t      grant,
   output logic          any_grant,
   output req_index_t    grant_index
);

   req_vec_t   member_grant;    // one winner per group, flat
   group_vec_t group_request;   // group has at least one request
   group_vec_t group_grant;     // one-hot winning group

   // input side
   group_arbiter_bank u_group_arbiter_bank (
      .clk           (clk),
      .reset         (reset),
      .request       (request),
      .group_grant   (group_grant),
      .priority_en   (priority_en),
      .member_grant  (member_grant),
      .group_request (group_request)
   );

   // picks among groups with a pending request
   // its any_grant already gates its own mask update
   thermo_rr_arbiter #(
      .WIDTH     (GROUP_NUM)
   ) u_group_select (
      .clk       (clk),
      .reset     (reset),
      .request   (group_request),
      .update_en (priority_en),
      .grant     (group_grant),
      .any_grant (any_grant)
   );

   // output side
   grant_combiner u_grant_combiner (
      .member_grant (member_grant),
      .group_grant  (group_grant),
      .grant        (grant),
      .grant_index  (grant_index)
   );

endmodule

`default_nettype wire

// ==== dv/arb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// watches the tree arbiter ports and compares them with a reference model
module arb_checker
   import arb_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       reset,
   input  wire req_vec_t   request,
   input  wire logic       priority_en,
   input  wire req_vec_t   grant,
   input  wire logic       any_grant,
   input  wire req_index_t grant_index,
   input  wire logic [7:0] test_id,
   input  wire logic       finish,
   output logic            done,
   output int              error_count
);

   // low GROUP_WIDTH bits for pulling one group out of a flat vector
   localparam req_vec_t GROUP_FIELD = req_vec_t'((1 << GROUP_WIDTH) - 1);

   req_vec_t   group_mask;    // group level model mask in the low GROUP_NUM bits
   req_vec_t   member_mask;   // GROUP_WIDTH mask bits per group
   logic [7:0] cur_test;
   int         test_errors;
   int         tests_passed;
   int         tests_failed;

   // lowest request inside the mask or else the lowest request overall
   // -1 when nothing requests
   function automatic int rr_pick(input req_vec_t req, input req_vec_t mask, input int width);
      int pick;
      pick = -1;
      for (int i = width - 1; i >= 0; i--) begin
         if (req[i]) pick = i;
      end
      for (int i = width - 1; i >= 0; i--) begin
         if (req[i] && mask[i]) pick = i;
      end
      return pick;
   endfunction

   // positions strictly above pos
   function automatic req_vec_t above(input int pos, input int width);
      req_vec_t mask;
      mask = '0;
      for (int i = 0; i < width; i++) begin
         mask[i] = (i > pos);
      end
      return mask;
   endfunction

   // winning requester under the two-level rule or -1
   function automatic int ref_winner(input req_vec_t req, input req_vec_t gmask,
                                     input req_vec_t mmask);
      req_vec_t grp_req;
      req_vec_t mem_req;
      req_vec_t mem_mask;
      int       g;
      int       m;
      grp_req = '0;
      for (int k = 0; k < GROUP_NUM; k++) begin
         grp_req[k] = |((req >> (k * GROUP_WIDTH)) & GROUP_FIELD);
      end
      g = rr_pick(grp_req, gmask, GROUP_NUM);
      if (g < 0) return -1;
      mem_req  = (req >> (g * GROUP_WIDTH)) & GROUP_FIELD;
      mem_mask = (mmask >> (g * GROUP_WIDTH)) & GROUP_FIELD;
      m = rr_pick(mem_req, mem_mask, GROUP_WIDTH);
      return g * GROUP_WIDTH + m;
   endfunction

   task automatic close_test(input logic [7:0] id);
      if (test_errors == 0) tests_passed++;
      else tests_failed++;
      $display("test %0d finished with %0d mismatches", id, test_errors);
   endtask

   always @(posedge clk) begin : sample
      int         win;
      int         g;
      req_vec_t   exp_grant;
      logic       exp_any;
      req_index_t exp_index;
      if (reset) begin
         group_mask   = '1;   // search from index 0 at both levels
         member_mask  = '1;
         cur_test     = '0;
         test_errors  = 0;
         tests_passed = 0;
         tests_failed = 0;
         error_count  = 0;
         done         = 1'b0;
      end else if (!done) begin
         if (!finish && test_id != cur_test) begin
            if (cur_test != 0) close_test(cur_test);
            cur_test    = test_id;
            test_errors = 0;
         end
         win       = ref_winner(request, group_mask, member_mask);
         exp_grant = '0;
         exp_any   = 1'b0;
         exp_index = '0;
         if (win >= 0) begin
            exp_grant = req_vec_t'(1) << win;
            exp_any   = 1'b1;
            exp_index = req_index_t'(win);
         end
         if (grant !== exp_grant || any_grant !== exp_any || grant_index !== exp_index) begin
            $display("[ERROR] %0t: test %0d exp grant %h any %b index %0d, got %h %b %0d",
                     $time, cur_test, exp_grant, exp_any, exp_index, grant, any_grant,
                     grant_index);
            error_count++;
            test_errors++;
         end
         // only the winning group and its member rotate
         if (priority_en && win >= 0) begin
            g           = win / GROUP_WIDTH;
            group_mask  = above(g, GROUP_NUM);
            member_mask = (member_mask & ~(GROUP_FIELD << (g * GROUP_WIDTH)))
                        | (above(win % GROUP_WIDTH, GROUP_WIDTH) << (g * GROUP_WIDTH));
         end
         if (finish) begin
            close_test(cur_test);
            $display("tests passed: %0d, tests failed: %0d, mismatches: %0d",
                     tests_passed, tests_failed, error_count);
            done = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== dv/tb_tree_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tree_arbiter
   import arb_pkg::*;
();

   localparam int CLK_PERIOD    = 100;
   localparam int RESET_CYCLES  = 3;
   localparam int WAIT_LIMIT    = 50;    // cycles allowed for any wait
   localparam int RANDOM_CYCLES = 600;

   logic       clk;
   logic       reset;
   req_vec_t   request;
   logic       priority_en;
   req_vec_t   grant;
   logic       any_grant;
   req_index_t grant_index;
   logic [7:0] test_id;
   logic       finish;
   logic       done;
   int         error_count;
   integer     seed;
   logic       timed_out;
   string      timeout_reason;

   tree_rr_arbiter u_tree_rr_arbiter (
      .clk         (clk),
      .reset       (reset),
      .request     (request),
      .priority_en (priority_en),
      .grant       (grant),
      .any_grant   (any_grant),
      .grant_index (grant_index)
   );

   arb_checker u_arb_checker (
      .clk         (clk),
      .reset       (reset),
      .request     (request),
      .priority_en (priority_en),
      .grant       (grant),
      .any_grant   (any_grant),
      .grant_index (grant_index),
      .test_id     (test_id),
      .finish      (finish),
      .done        (done),
      .error_count (error_count)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

   task automatic wait_reset_release(output logic ok);
      int cnt;
      cnt = 0;
      while (reset !== 1'b0 && cnt < WAIT_LIMIT) begin
         @(negedge clk);
         cnt++;
      end
      ok = (reset === 1'b0);
   endtask

   task automatic wait_checker_done(output logic ok);
      int cnt;
      cnt = 0;
      while (done !== 1'b1 && cnt < WAIT_LIMIT) begin
         @(negedge clk);
         cnt++;
      end
      ok = (done === 1'b1);
   endtask

   // one cycle of stimulus for the next rising edge
   task automatic drive(input req_vec_t req, input logic strobe);
      @(negedge clk);
      request     = req;
      priority_en = strobe;
   endtask

   task automatic begin_test(input logic [7:0] id);
      @(negedge clk);
      test_id     = id;
      request     = '0;
      priority_en = 1'b0;
   endtask

   task automatic single_request_test();
      begin_test(8'd1);
      for (int i = 0; i < NUM_REQ; i++) drive(req_vec_t'(1) << i, 1'b0);
   endtask

   task automatic rotation_test();
      begin_test(8'd2);
      repeat (NUM_REQ) drive('1, 1'b1);   // groups first, then members
   endtask

   task automatic hold_test();
      begin_test(8'd3);
      repeat (5) drive(16'h0a21, 1'b0);
      drive(16'h0a21, 1'b1);
      repeat (4) drive(16'h0a21, 1'b0);
   endtask

   task automatic idle_test();
      begin_test(8'd4);
      repeat (2) drive('0, 1'b0);
      drive('0, 1'b1);   // no grant and so no rotation
      drive('0, 1'b0);
      repeat (2) drive(16'h1111, 1'b0);
      drive(16'h1111, 1'b1);
      drive(16'h1111, 1'b0);
   endtask

   task automatic random_test();
      logic [31:0] rnd;
      req_vec_t    req;
      begin_test(8'd5);
      for (int i = 0; i < RANDOM_CYCLES; i++) begin
         rnd = $random(seed);
         req = rnd[15:0];
         if (rnd[19:17] == 3'd0) req = req & rnd[31:16];   // sparser requests now and then
         drive(req, rnd[16]);
      end
   endtask

   initial begin : stimulus
      logic ok;
      request        = '0;
      priority_en    = 1'b0;
      test_id        = '0;
      finish         = 1'b0;
      seed           = 32'hca86;
      timed_out      = 1'b0;
      timeout_reason = "";
      wait_reset_release(ok);
      if (!ok) begin
         timed_out      = 1'b1;
         timeout_reason = "timeout: reset was never released";
      end else begin
         single_request_test();
         rotation_test();
         hold_test();
         idle_test();
         random_test();
         @(negedge clk);
         finish = 1'b1;
         wait_checker_done(ok);
         if (!ok) begin
            timed_out      = 1'b1;
            timeout_reason = "timeout: checker never reported its summary";
         end
      end
      if (timed_out) begin
         $display("%s", timeout_reason);
         $display("Verification failed");
      end else if (error_count == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
source/arb_pkg.sv
source/thermo_rr_arbiter.sv
source/group_arbiter_bank.sv
source/grant_combiner.sv
source/tree_rr_arbiter.sv
dv/arb_checker.sv
dv/tb_tree_arbiter.sv

// ==== Makefile ====
# Verilator build and run of the tree arbiter testbench

VERILATOR ?= verilator
TOP       ?= tb_tree_arbiter
BUILD_DIR ?= build
LOG       ?= sim.log
# extra runtime arguments for the simulator binary, e.g. +verilator+seed+7
SEED_ARGS ?=

FLIST   := flist.f
SOURCES := $(filter-out +%,$(shell cat $(FLIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a listed source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	$(SIM_BIN) $(SEED_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Verification passed" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
